// ==== design/armCtrlPkg.sv ====
package armCtrlPkg;

  // Decoded instruction class
  typedef enum logic [2:0] {
    clsDataImm,
    clsDataReg,
    clsLoad,
    clsStore,
    clsBranch,
    clsUndef
  } instrClassT;

  // Data-processing opcodes, instruction bits 24:21
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,  // Also the address add for LDR, STR and B
    opAdc = 4'b0101,
    opSbc = 4'b0110,
    opRsc = 4'b0111,
    opTst = 4'b1000,
    opTeq = 4'b1001,
    opCmp = 4'b1010,
    opCmn = 4'b1011,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } aluOpT;

  // Condition field, instruction bits 31:28
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl
  } condT;

  localparam logic [3:0] condNever = 4'b1111;  // No-op encoding

  // NZCV positions in a flags vector
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

endpackage

// ==== design/mainDecoder.sv ====
module mainDecoder (
  input  logic [31:0]       instrD,
  output logic [1:0]        regSrcD,
  output logic [1:0]        immSrcD,
  output logic              aluSrcD,
  output logic              memtoRegD,
  output logic              regWriteD,
  output logic              memWriteD,
  output logic              branchD,
  output logic              pcSrcD,
  output logic              swapAluInputsD,
  output logic              shiftTypeD,
  output armCtrlPkg::aluOpT aluControlD,
  output logic [1:0]        flagWriteD,
  output armCtrlPkg::condT  condD
);
  import armCtrlPkg::*;

  instrClassT cls;
  aluOpT      opD;
  logic       dataProc;
  logic       isCompare;
  logic       isArith;

  assign opD       = aluOpT'(instrD[24:21]);
  assign condD     = condT'(instrD[31:28]);
  assign dataProc  = (cls == clsDataImm) || (cls == clsDataReg);
  assign isCompare = opD inside {opTst, opTeq, opCmp, opCmn};  // No register result
  assign isArith   = opD inside {opAdd, opSub, opRsb, opAdc, opSbc, opRsc, opCmp, opCmn};

  always_comb begin
    cls = clsUndef;
    if (instrD[31:28] != condNever) begin
      case (instrD[27:26])
        2'b00: begin
          if (instrD[25])
            cls = clsDataImm;
          else if (instrD[7:4] != 4'b1001)  // Skip multiply space
            cls = clsDataReg;
        end
        2'b01: begin
          // Immediate offset only
          if (!instrD[25])
            cls = instrD[20] ? clsLoad : clsStore;
        end
        2'b10: begin
          if (instrD[25] && !instrD[24])  // B, not BL
            cls = clsBranch;
        end
        default: cls = clsUndef;
      endcase
    end
  end

  always_comb begin
    regSrcD     = 2'b00;
    immSrcD     = 2'b00;
    aluSrcD     = 1'b0;
    memtoRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    aluControlD = opAdd;
    flagWriteD  = 2'b00;
    case (cls)
      clsDataImm, clsDataReg: begin
        aluSrcD     = (cls == clsDataImm);
        regWriteD   = !isCompare;
        aluControlD = opD;
        flagWriteD  = {instrD[20], instrD[20] & isArith};  // S bit gates both pairs
      end
      clsLoad: begin
        immSrcD   = 2'b01;
        aluSrcD   = 1'b1;
        memtoRegD = 1'b1;
        regWriteD = 1'b1;
      end
      clsStore: begin
        regSrcD   = 2'b10;  // Rd read as store data
        immSrcD   = 2'b01;
        aluSrcD   = 1'b1;
        memWriteD = 1'b1;
      end
      clsBranch: begin
        regSrcD = 2'b01;  // PC as base
        immSrcD = 2'b10;
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: ;
    endcase
  end

  assign pcSrcD         = (regWriteD && instrD[15:12] == 4'hF) || branchD;
  assign swapAluInputsD = dataProc && (opD == opRsb || opD == opRsc);
  assign shiftTypeD     = (cls == clsDataReg) && !instrD[4];  // Immediate shift amount

endmodule

// ==== design/condUnit.sv ====
module condUnit (
  input  logic             clk,
  input  logic             arstN,
  input  logic             enE,
  input  armCtrlPkg::condT condE,
  input  logic [3:0]       aluFlagsE,
  input  logic [1:0]       flagWriteE,
  output logic             condExE,
  output logic             carryInE,
  output logic [3:0]       flags
);
  import armCtrlPkg::*;

  logic neg;
  logic zero;
  logic carry;
  logic ovf;
  logic ge;
  logic updNz;
  logic updCv;

  assign neg   = flags[flagN];
  assign zero  = flags[flagZ];
  assign carry = flags[flagC];
  assign ovf   = flags[flagV];
  assign ge    = (neg == ovf);

  always_comb begin
    case (condE)
      condEq:  condExE = zero;
      condNe:  condExE = !zero;
      condCs:  condExE = carry;
      condCc:  condExE = !carry;
      condMi:  condExE = neg;
      condPl:  condExE = !neg;
      condVs:  condExE = ovf;
      condVc:  condExE = !ovf;
      condHi:  condExE = carry && !zero;
      condLs:  condExE = !carry || zero;
      condGe:  condExE = ge;
      condLt:  condExE = !ge;
      condGt:  condExE = !zero && ge;
      condLe:  condExE = zero || !ge;
      condAl:  condExE = 1'b1;
      default: condExE = 1'b0;  // Never
    endcase
  end

  // Only while Execute advances
  assign updNz = enE && condExE && flagWriteE[1];
  assign updCv = enE && condExE && flagWriteE[0];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= 4'b0000;
    end else begin
      if (updNz) begin
        flags[flagN] <= aluFlagsE[flagN];
        flags[flagZ] <= aluFlagsE[flagZ];
      end
      if (updCv) begin
        flags[flagC] <= aluFlagsE[flagC];
        flags[flagV] <= aluFlagsE[flagV];
      end
    end
  end

  assign carryInE = carry;  // ADC, SBC, RSC carry in

endmodule

// ==== design/ctrlPipeline.sv ====
module ctrlPipeline (
  input  logic              clk,
  input  logic              arstN,
  input  logic              aluSrcD,
  input  armCtrlPkg::aluOpT aluControlD,
  input  logic              swapAluInputsD,
  input  logic              shiftTypeD,
  input  logic [1:0]        flagWriteD,
  input  armCtrlPkg::condT  condD,
  input  logic              memtoRegD,
  input  logic              regWriteD,
  input  logic              memWriteD,
  input  logic              branchD,
  input  logic              pcSrcD,
  input  logic              condExE,
  input  logic              stallE,
  input  logic              flushE,
  input  logic              stallM,
  input  logic              flushW,
  output logic              aluSrcE,
  output armCtrlPkg::aluOpT aluControlE,
  output logic              swapAluInputsE,
  output logic              shiftTypeE,
  output logic [1:0]        flagWriteE,
  output armCtrlPkg::condT  condE,
  output logic              memtoRegE,
  output logic              branchTakenE,
  output logic              enE,
  output logic              memWriteM,
  output logic              memtoRegM,
  output logic              regWriteM,
  output logic              memtoRegW,
  output logic              regWriteW,
  output logic              pcSrcW,
  output logic              pcWrPendingF
);
  import armCtrlPkg::*;

  logic regWriteE;
  logic memWriteE;
  logic branchE;
  logic pcSrcE;
  logic pcSrcM;

  assign enE = !stallE;

  // Execute controls that a bubble must clear
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {flagWriteE, memtoRegE, regWriteE, memWriteE, branchE, pcSrcE} <= '0;
    end else if (enE) begin
      if (flushE)
        {flagWriteE, memtoRegE, regWriteE, memWriteE, branchE, pcSrcE} <= '0;
      else
        {flagWriteE, memtoRegE, regWriteE, memWriteE, branchE, pcSrcE} <=
          {flagWriteD, memtoRegD, regWriteD, memWriteD, branchD, pcSrcD};
    end
  end

  // Operation fields, harmless in a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      aluSrcE        <= 1'b0;
      aluControlE    <= opAnd;
      swapAluInputsE <= 1'b0;
      shiftTypeE     <= 1'b0;
      condE          <= condAl;
    end else if (enE) begin
      aluSrcE        <= aluSrcD;
      aluControlE    <= aluControlD;
      swapAluInputsE <= swapAluInputsD;
      shiftTypeE     <= shiftTypeD;
      condE          <= condD;
    end
  end

  assign branchTakenE = branchE && condExE;

  // Writes are dropped here when the condition fails
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM} <= '0;
    end else if (!stallM) begin
      memWriteM <= memWriteE && condExE;
      memtoRegM <= memtoRegE;
      regWriteM <= regWriteE && condExE;
      pcSrcM    <= pcSrcE && condExE;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      {memtoRegW, regWriteW, pcSrcW} <= '0;
    else if (flushW)
      {memtoRegW, regWriteW, pcSrcW} <= '0;  // Bubble while memory waits
    else
      {memtoRegW, regWriteW, pcSrcW} <= {memtoRegM, regWriteM, pcSrcM};
  end

  assign pcWrPendingF = pcSrcD || pcSrcE || pcSrcM;

endmodule

// ==== design/hazardUnit.sv ====
module hazardUnit (
  input  logic [3:0] ra1D,
  input  logic [3:0] ra2D,
  input  logic [3:0] wa3E,
  input  logic       memtoRegE,
  input  logic       branchTakenE,
  input  logic       pcWrPendingF,
  input  logic       memReady,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE,
  output logic       stallE,
  output logic       stallM,
  output logic       flushW
);

  logic ldStall;
  logic memWait;

  // Load result not ready for the instruction behind it
  assign ldStall = memtoRegE && ((wa3E == ra1D) || (wa3E == ra2D));
  assign memWait = !memReady;

  always_comb begin
    stallF = 1'b0;
    stallD = 1'b0;
    flushD = 1'b0;
    flushE = 1'b0;
    stallE = 1'b0;
    stallM = 1'b0;
    flushW = 1'b0;
    if (memWait) begin
      // Freeze everything up to Memory
      stallF = 1'b1;
      stallD = 1'b1;
      stallE = 1'b1;
      stallM = 1'b1;
      flushW = 1'b1;
    end else begin
      stallD = ldStall;
      stallF = ldStall || pcWrPendingF;  // Hold fetch until the PC is written
      flushE = ldStall || branchTakenE;
      flushD = branchTakenE;             // Wrong-path instruction in Decode
    end
  end

endmodule

// ==== design/armCtrl.sv ====
module armCtrl (
  input  logic              clk,
  input  logic              arstN,
  input  logic [31:0]       instrD,
  input  logic [3:0]        aluFlagsE,
  input  logic              memReady,
  output logic [1:0]        regSrcD,
  output logic [1:0]        immSrcD,
  output logic              aluSrcE,
  output armCtrlPkg::aluOpT aluControlE,
  output logic              swapAluInputsE,
  output logic              shiftTypeE,
  output logic              memtoRegE,
  output logic              branchTakenE,
  output logic              carryInE,
  output logic [3:0]        flags,
  output logic              memWriteM,
  output logic              memtoRegM,
  output logic              regWriteM,
  output logic              memtoRegW,
  output logic              regWriteW,
  output logic              pcSrcW,
  output logic              stallF,
  output logic              stallD,
  output logic              flushD,
  output logic              flushE,
  output logic              stallE,
  output logic              stallM,
  output logic              flushW
);
  import armCtrlPkg::*;

  aluOpT      aluControlD;
  condT       condD;
  condT       condE;
  logic [1:0] flagWriteD;
  logic [1:0] flagWriteE;
  logic       aluSrcD;
  logic       memtoRegD;
  logic       regWriteD;
  logic       memWriteD;
  logic       branchD;
  logic       pcSrcD;
  logic       swapAluInputsD;
  logic       shiftTypeD;
  logic       condExE;
  logic       enE;
  logic       pcWrPendingF;
  logic [3:0] ra1D;
  logic [3:0] ra2D;
  logic [3:0] wa3E;

  assign ra1D = regSrcD[0] ? 4'hF : instrD[19:16];           // Branch reads the PC
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];    // Store data register

  // Destination register follows the instruction into Execute
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      wa3E <= 4'h0;
    else if (enE)
      wa3E <= instrD[15:12];
  end

  mainDecoder decoder_i (
    .instrD        (instrD),
    .regSrcD       (regSrcD),
    .immSrcD       (immSrcD),
    .aluSrcD       (aluSrcD),
    .memtoRegD     (memtoRegD),
    .regWriteD     (regWriteD),
    .memWriteD     (memWriteD),
    .branchD       (branchD),
    .pcSrcD        (pcSrcD),
    .swapAluInputsD(swapAluInputsD),
    .shiftTypeD    (shiftTypeD),
    .aluControlD   (aluControlD),
    .flagWriteD    (flagWriteD),
    .condD         (condD)
  );

  ctrlPipeline pipe_i (
    .clk           (clk),
    .arstN         (arstN),
    .aluSrcD       (aluSrcD),
    .aluControlD   (aluControlD),
    .swapAluInputsD(swapAluInputsD),
    .shiftTypeD    (shiftTypeD),
    .flagWriteD    (flagWriteD),
    .condD         (condD),
    .memtoRegD     (memtoRegD),
    .regWriteD     (regWriteD),
    .memWriteD     (memWriteD),
    .branchD       (branchD),
    .pcSrcD        (pcSrcD),
    .condExE       (condExE),
    .stallE        (stallE),
    .flushE        (flushE),
    .stallM        (stallM),
    .flushW        (flushW),
    .aluSrcE       (aluSrcE),
    .aluControlE   (aluControlE),
    .swapAluInputsE(swapAluInputsE),
    .shiftTypeE    (shiftTypeE),
    .flagWriteE    (flagWriteE),
    .condE         (condE),
    .memtoRegE     (memtoRegE),
    .branchTakenE  (branchTakenE),
    .enE           (enE),
    .memWriteM     (memWriteM),
    .memtoRegM     (memtoRegM),
    .regWriteM     (regWriteM),
    .memtoRegW     (memtoRegW),
    .regWriteW     (regWriteW),
    .pcSrcW        (pcSrcW),
    .pcWrPendingF  (pcWrPendingF)
  );

  condUnit cond_i (
    .clk       (clk),
    .arstN     (arstN),
    .enE       (enE),
    .condE     (condE),
    .aluFlagsE (aluFlagsE),
    .flagWriteE(flagWriteE),
    .condExE   (condExE),
    .carryInE  (carryInE),
    .flags     (flags)
  );

  hazardUnit hazard_i (
    .ra1D        (ra1D),
    .ra2D        (ra2D),
    .wa3E        (wa3E),
    .memtoRegE   (memtoRegE),
    .branchTakenE(branchTakenE),
    .pcWrPendingF(pcWrPendingF),
    .memReady    (memReady),
    .stallF      (stallF),
    .stallD      (stallD),
    .flushD      (flushD),
    .flushE      (flushE),
    .stallE      (stallE),
    .stallM      (stallM),
    .flushW      (flushW)
  );

endmodule

// ==== bench/armCtrl_properties.sv ====
module armCtrlProperties (
  input logic              clk,
  input logic              arstN,
  input logic              memReady,
  input logic              branchTakenE,
  input logic              flushE,
  input logic              stallF,
  input logic              stallD,
  input logic              stallE,
  input logic              stallM,
  input logic              aluSrcE,
  input armCtrlPkg::aluOpT aluControlE,
  input logic              swapAluInputsE,
  input logic              shiftTypeE,
  input logic              memtoRegE
);
  timeunit 1ns;
  timeprecision 1ps;

  int failCount = 0;  // Failed assertions so far

  // Memory wait outranks the branch flush
  flushOnBranch: assert property (@(posedge clk) disable iff (!arstN)
    branchTakenE && memReady |-> flushE)
    else begin
      $error("flushE missing in the cycle of a taken branch");
      failCount++;
    end

  quietInReset: assert property (@(posedge clk)
    !arstN |-> !(stallF || stallD || stallE || stallM))
    else begin
      $error("stall raised while reset is active");
      failCount++;
    end

  fetchFollowsDecode: assert property (@(posedge clk) disable iff (!arstN)
    stallD |-> stallF)
    else begin
      $error("stallD high without stallF");
      failCount++;
    end

  // Execute controls frozen across a memory wait
  holdOnMemWait: assert property (@(posedge clk) disable iff (!arstN)
    !memReady |=> $stable({aluSrcE, aluControlE, swapAluInputsE, shiftTypeE, memtoRegE}))
    else begin
      $error("Execute controls changed while memory was not ready");
      failCount++;
    end

endmodule

bind armCtrl armCtrlProperties props_i (
  .clk           (clk),
  .arstN         (arstN),
  .memReady      (memReady),
  .branchTakenE  (branchTakenE),
  .flushE        (flushE),
  .stallF        (stallF),
  .stallD        (stallD),
  .stallE        (stallE),
  .stallM        (stallM),
  .aluSrcE       (aluSrcE),
  .aluControlE   (aluControlE),
  .swapAluInputsE(swapAluInputsE),
  .shiftTypeE    (shiftTypeE),
  .memtoRegE     (memtoRegE)
);

// ==== bench/armCtrlTb.sv ====
module armCtrlTb;
  timeunit 1ns;
  timeprecision 1ps;
  import armCtrlPkg::*;

  localparam int numInstr = 2000;
  localparam int clkPeriod = 4;
  localparam logic [31:0] nopInstr = 32'hF000_0000;  // Condition never

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    aluOpT      aluCtl;
    logic       swap;
    logic       shiftType;
    logic [1:0] flagWrite;
    logic [3:0] cond;
    logic       memtoReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       pcSrc;
    logic [3:0] rd;
  } ctrlT;

  logic        clk;
  logic        arstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic        memReady;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  aluOpT       aluControlE;
  logic        swapAluInputsE;
  logic        shiftTypeE;
  logic        memtoRegE;
  logic        branchTakenE;
  logic        carryInE;
  logic [3:0]  flags;
  logic        memWriteM;
  logic        memtoRegM;
  logic        regWriteM;
  logic        memtoRegW;
  logic        regWriteW;
  logic        pcSrcW;
  logic        stallF;
  logic        stallD;
  logic        flushD;
  logic        flushE;
  logic        stallE;
  logic        stallM;
  logic        flushW;

  // Reference pipeline
  ctrlT       curD;
  ctrlT       stE;
  instrClassT curCls;
  logic       eValid;
  logic       mMemWrite;
  logic       mMemtoReg;
  logic       mRegWrite;
  logic       mPcSrc;
  logic       wMemtoReg;
  logic       wRegWrite;
  logic       wPcSrc;
  logic [3:0] modelFlags;
  logic       condOk;
  logic       xStallF;
  logic       xStallD;
  logic       xFlushD;
  logic       xFlushE;
  logic       xStallE;
  logic       xStallM;
  logic       xFlushW;
  logic       xTaken;

  integer     seed;
  logic [3:0] lastRd;
  int         errors;
  int         assertFails;
  int         checks;
  int         issued;
  int         drainCycles;
  int         loadStalls;

  armCtrl dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Generous bound on the whole run
  initial begin
    #(numInstr * 10 * clkPeriod);
    $display("Watchdog expired before the instruction stream drained");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic condPasses(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    n = f[flagN];
    z = f[flagZ];
    c = f[flagC];
    v = f[flagV];
    case (condT'(cond))
      condEq:  return z;
      condNe:  return !z;
      condCs:  return c;
      condCc:  return !c;
      condMi:  return n;
      condPl:  return !n;
      condVs:  return v;
      condVc:  return !v;
      condHi:  return c && !z;
      condLs:  return !c || z;
      condGe:  return n == v;
      condLt:  return n != v;
      condGt:  return !z && (n == v);
      condLe:  return z || (n != v);
      condAl:  return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ctrlT decodeRef(input logic [31:0] instr, input instrClassT cls);
    ctrlT  c;
    aluOpT op;
    logic  noResult;
    logic  arith;
    op       = aluOpT'(instr[24:21]);
    noResult = op inside {opTst, opTeq, opCmp, opCmn};
    arith    = op inside {opAdd, opAdc, opSub, opSbc, opRsb, opRsc, opCmp, opCmn};
    c        = '0;
    c.aluCtl = opAdd;  // Address add unless data processing
    c.cond   = instr[31:28];
    c.rd     = instr[15:12];
    case (cls)
      clsDataImm, clsDataReg: begin
        c.aluSrc    = (cls == clsDataImm);
        c.aluCtl    = op;
        c.regWrite  = !noResult;
        c.flagWrite = {instr[20], instr[20] && arith};
        c.swap      = (op == opRsb) || (op == opRsc);
        c.shiftType = (cls == clsDataReg) && !instr[4];
      end
      clsLoad: begin
        c.immSrc   = 2'b01;
        c.aluSrc   = 1'b1;
        c.memtoReg = 1'b1;
        c.regWrite = 1'b1;
      end
      clsStore: begin
        c.regSrc   = 2'b10;
        c.immSrc   = 2'b01;
        c.aluSrc   = 1'b1;
        c.memWrite = 1'b1;
      end
      clsBranch: begin
        c.regSrc = 2'b01;
        c.immSrc = 2'b10;
        c.aluSrc = 1'b1;
        c.branch = 1'b1;
      end
      default: ;
    endcase
    c.pcSrc = c.branch || (c.regWrite && c.rd == 4'hF);
    return c;
  endfunction

  task automatic randomInstr(output logic [31:0] instr, output instrClassT cls);
    int         pick;
    logic [3:0] cond;
    pick  = {$random(seed)} % 20;
    cond  = ({$random(seed)} % 2 == 0) ? 4'hE : 4'({$random(seed)} % 15);
    instr = $random(seed);
    instr[31:28] = cond;
    if (pick < 9) begin
      instr[27:26] = 2'b00;
      if (!instr[25])
        instr[7] = 1'b0;  // Stay clear of the multiply space
      cls = instr[25] ? clsDataImm : clsDataReg;
    end else if (pick < 13) begin
      instr[27:25] = 3'b010;
      instr[20]    = 1'b1;
      cls          = clsLoad;
    end else if (pick < 16) begin
      instr[27:25] = 3'b010;
      instr[20]    = 1'b0;
      cls          = clsStore;
    end else if (pick < 19) begin
      instr[27:24] = 4'b1010;
      cls          = clsBranch;
    end else begin
      instr[27:26] = 2'b11;  // Coprocessor space
      cls          = clsUndef;
    end
    // Reuse the previous destination as a source
    if (({$random(seed)} % 5) < 2) begin
      if (cls == clsStore)
        instr[15:12] = lastRd;
      else if ({$random(seed)} % 2 == 0)
        instr[19:16] = lastRd;
      else
        instr[3:0] = lastRd;
    end
    lastRd = instr[15:12];
  endtask

  task automatic compareField(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkReset();
    compareField("write enables and flags in reset",
      8'({regWriteW, memWriteM, pcSrcW, branchTakenE, flags}), 8'h00);
    compareField("stall and flush in reset",
      8'({stallF, stallD, flushD, flushE, stallE, stallM, flushW}), 8'h00);
  endtask

  // Environment side of Fetch, honoring the hold rule
  task automatic presentNext();
    aluFlagsE = 4'($random(seed));
    if (xStallD) begin
      // Same instruction stays in Decode
    end else if (xFlushD || xStallF || issued >= numInstr) begin
      instrD = nopInstr;
      curCls = clsUndef;
    end else begin
      randomInstr(instrD, curCls);
      issued++;
    end
    if (issued >= numInstr)
      drainCycles++;
    memReady = (issued >= numInstr) || (({$random(seed)} % 10) != 0);
  endtask

  task automatic checkOutputs();
    logic [3:0] ra1;
    logic [3:0] ra2;
    logic       ldStall;
    logic       pending;
    logic       memWait;
    curD    = decodeRef(instrD, curCls);
    ra1     = curD.regSrc[0] ? 4'hF : instrD[19:16];
    ra2     = curD.regSrc[1] ? instrD[15:12] : instrD[3:0];
    condOk  = condPasses(stE.cond, modelFlags);
    xTaken  = stE.branch && condOk;
    ldStall = stE.memtoReg && ((stE.rd == ra1) || (stE.rd == ra2));
    pending = curD.pcSrc || stE.pcSrc || mPcSrc;
    memWait = !memReady;
    xStallE = memWait;
    xStallM = memWait;
    xFlushW = memWait;
    xStallD = memWait || ldStall;
    xStallF = memWait || ldStall || pending;
    xFlushE = !memWait && (ldStall || xTaken);
    xFlushD = !memWait && xTaken;
    if (!memWait && ldStall)
      loadStalls++;

    compareField("Decode selects", 8'({regSrcD, immSrcD}), 8'({curD.regSrc, curD.immSrc}));
    if (eValid)
      compareField("Execute operation", 8'({aluSrcE, aluControlE, swapAluInputsE, shiftTypeE}),
        8'({stE.aluSrc, stE.aluCtl, stE.swap, stE.shiftType}));
    compareField("Execute load and branch", 8'({memtoRegE, branchTakenE}),
      8'({stE.memtoReg, xTaken}));
    compareField("flags and carry", 8'({flags, carryInE}),
      8'({modelFlags, modelFlags[flagC]}));
    compareField("Memory controls", 8'({memWriteM, memtoRegM, regWriteM}),
      8'({mMemWrite, mMemtoReg, mRegWrite}));
    compareField("Writeback controls", 8'({memtoRegW, regWriteW, pcSrcW}),
      8'({wMemtoReg, wRegWrite, wPcSrc}));
    compareField("stall and flush", 8'({stallF, stallD, flushD, flushE, stallE, stallM, flushW}),
      8'({xStallF, xStallD, xFlushD, xFlushE, xStallE, xStallM, xFlushW}));
  endtask

  // Clock edge of the reference pipeline
  task automatic stepModel();
    if (!xStallE && condOk) begin
      if (stE.flagWrite[1]) begin
        modelFlags[flagN] = aluFlagsE[flagN];
        modelFlags[flagZ] = aluFlagsE[flagZ];
      end
      if (stE.flagWrite[0]) begin
        modelFlags[flagC] = aluFlagsE[flagC];
        modelFlags[flagV] = aluFlagsE[flagV];
      end
    end
    if (xFlushW)
      {wMemtoReg, wRegWrite, wPcSrc} = 3'b000;
    else
      {wMemtoReg, wRegWrite, wPcSrc} = {mMemtoReg, mRegWrite, mPcSrc};
    if (!xStallM) begin
      mMemWrite = stE.memWrite && condOk;
      mMemtoReg = stE.memtoReg;
      mRegWrite = stE.regWrite && condOk;
      mPcSrc    = stE.pcSrc && condOk;
    end
    if (!xStallE) begin
      stE    = curD;
      eValid = !xFlushE;
      if (xFlushE) begin  // Bubble
        stE.flagWrite = 2'b00;
        {stE.memtoReg, stE.regWrite, stE.memWrite, stE.branch, stE.pcSrc} = 5'b00000;
      end
    end
  endtask

  initial begin
    seed        = 9;
    errors      = 0;
    assertFails = 0;
    checks      = 0;
    issued      = 0;
    drainCycles = 0;
    loadStalls  = 0;
    lastRd      = 4'h0;
    arstN       = 1'b0;
    instrD      = nopInstr;
    curCls      = clsUndef;
    aluFlagsE   = 4'h0;
    memReady    = 1'b1;
    stE         = '0;
    stE.cond    = 4'hE;  // Matches the reset condition of Execute
    eValid      = 1'b0;
    modelFlags  = 4'h0;
    condOk      = 1'b1;
    {mMemWrite, mMemtoReg, mRegWrite, mPcSrc} = 4'h0;
    {wMemtoReg, wRegWrite, wPcSrc} = 3'b000;
    {xStallF, xStallD, xFlushD, xFlushE, xStallE, xStallM, xFlushW, xTaken} = 8'h00;

    repeat (8) begin
      @(negedge clk);
      checkReset();
    end
    arstN = 1'b1;

    while (drainCycles < 12) begin
      presentNext();
      #1;  // Settle before sampling
      checkOutputs();
      stepModel();
      @(negedge clk);
    end

    assertFails = dut_i.props_i.failCount;
    $display(
      "Checks %0d, errors %0d, assertion failures %0d, instructions %0d, load-use stalls %0d",
      checks, errors, assertFails, issued, loadStalls);
    if (errors == 0 && assertFails == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== armCtrl.f ====
design/armCtrlPkg.sv
design/mainDecoder.sv
design/condUnit.sv
design/ctrlPipeline.sv
design/hazardUnit.sv
design/armCtrl.sv
bench/armCtrl_properties.sv
bench/armCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module armCtrlTb \
  -f armCtrl.f --Mdir obj_dir -o armCtrlSim \
  && ./obj_dir/armCtrlSim | tee sim.log \
  || { echo "Verilator build or simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
